// ==== gps_channel_top.f ====
hdl/gps_pkg.sv
hdl/sample_pacer.sv
hdl/carrier_nco.sv
hdl/ca_code_gen.sv
hdl/correlator.sv
hdl/result_credit_tx.sv
hdl/status_display.sv
hdl/gps_channel_top.sv
verif/tb_gps_channel.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the GPS channel testbench with Verilator, result taken from sim.log
verilator --binary --timing --top-module tb_gps_channel -f gps_channel_top.f \
   -o tb_gps_channel &&
./obj_dir/tb_gps_channel | tee sim.log &&
grep -q "^ALL CHECKS PASSED$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== verif/tb_gps_channel.sv ====
module tb_gps_channel import gps_pkg::*; ();

   localparam int SAMPLES_PER_CHIP = 2;          // code_inc_i of 2^31
   localparam int FULL_DUMPS       = 19;         // Dumps at full rate over all tests
   localparam int DIV_DUMPS        = 1;          // Dumps at divided rate
   localparam int CLK_PERIOD       = 4;
   localparam int WATCHDOG_TIME    = 2 * CLK_PERIOD * CODE_LEN * SAMPLES_PER_CHIP
                                     * (FULL_DUMPS + DIV_DUMPS * PACE_DIV);
   localparam int DUMPS_HELD       = RES_FIFO_DEPTH + CREDIT_INIT + 2; // Forces two drops
   localparam int COS_REF [8] = '{3, 1, -1, -3, -3, -1, 1, 3};     // Octant 0 first
   localparam int SIN_REF [8] = '{1, 3, 3, 1, -1, -3, -3, -1};
   localparam logic [SEG_W-1:0] SEG_REF [16] = '{                   // gfedcba, active low
      7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
      7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

   logic clk_16_8 = 1'b0;
   logic rst_n_i, sample_valid_i, full_rate_i, credit_return_i;
   logic [SAMPLE_W-1:0] sample_data_i;
   logic [PRN_W-1:0] prn_i;
   logic [NCO_W-1:0] code_inc_i, carrier_inc_i;
   logic [DISP_SEL_W-1:0] disp_sel_i;
   logic ca_bit_o, result_valid_o, overflow_o;
   logic signed [ACC_W-1:0] result_i_o, result_q_o;
   logic [SEG_W-1:0] hex0_o, hex1_o, hex2_o, hex3_o;

   // Reference model state, mirrors DUT state after the last edge
   int m_div, m_chip_idx, m_acc_i, m_acc_q, m_credits, m_dump_cnt;
   logic m_tick, m_dump_v, m_res_v, m_ovf;
   logic [NCO_W-1:0] m_carr_ph, m_code_ph;
   logic [1:10] m_g1, m_g2;                      // Index = stage number
   logic signed [ACC_W-1:0] m_dump_i, m_dump_q, m_res_i, m_res_q, m_last_i, m_last_q;
   logic signed [ACC_W-1:0] fifo_i [$];
   logic signed [ACC_W-1:0] fifo_q [$];
   int results_seen, owed;                       // Host side bookkeeping
   int errors = 0;
   int tests = 0;
   int err_start;
   string test_name;
   logic [15:0] lfsr_state = 16'd83;

   gps_channel_top UUT (.*);

   always #2 clk_16_8 = ~clk_16_8;

   // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
   function automatic logic [31:0] lfsr_take(input int nbits);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int k = 0; k < nbits; k++) begin
         fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         val        = {val[30:0], fb};
      end
      return val;
   endfunction

   task automatic check_acc(input string what, input logic signed [ACC_W-1:0] exp, act);
      if (act !== exp) begin
         errors++;
         $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      end
   endtask

   task automatic check_hex(input string what, input logic [SEG_W-1:0] exp, act);
      if (act !== exp) begin
         errors++;
         $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_chip(input string what, input logic exp, act);
      if (act !== exp) begin
         errors++;
         $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_flag(input string what, input logic exp, act);
      if (act !== exp) begin
         errors++;
         $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      err_start = errors;
   endtask

   task automatic end_test();
      tests++;
      $display("test %s: %0d errors", test_name, errors - err_start);
   endtask

   // Leaves time at rising edge + 1 with model cleared
   task automatic apply_reset();
      rst_n_i         = 1'b0;
      sample_valid_i  = 1'b0;
      credit_return_i = 1'b0;
      repeat (16) @(posedge clk_16_8);
      #1;
      rst_n_i      = 1'b1;
      m_div        = PACE_DIV - 1;
      m_tick       = 1'b0;
      m_carr_ph    = '0;
      m_code_ph    = '0;
      m_chip_idx   = 0;
      m_g1         = '1;
      m_g2         = '1;
      m_acc_i      = 0;
      m_acc_q      = 0;
      m_dump_v     = 1'b0;
      m_res_v      = 1'b0;
      m_ovf        = 1'b0;
      m_credits    = CREDIT_INIT;
      m_last_i     = '0;
      m_last_q     = '0;
      m_dump_cnt   = 0;
      fifo_i.delete();
      fifo_q.delete();
      results_seen = 0;
      owed         = 0;
   endtask

   // Drive one clock, check settled outputs, then step the model over the next edge
   task automatic run_cycle(input logic valid, input logic cret);
      logic               en;
      logic               chip;
      logic               ep;
      logic               full;
      logic               pop;
      logic [NCO_W:0]     csum;
      logic [2*TAP_W-1:0] taps;
      logic [ACC_W-1:0]   dval;
      int                 s;
      int                 ti;
      int                 tq;
      sample_valid_i  = valid;
      credit_return_i = cret;
      sample_data_i   = SAMPLE_W'(lfsr_take(SAMPLE_W));
      if (cret) owed--;
      #1;
      taps = G2_TAPS[prn_i];
      chip = m_g1[10] ^ m_g2[taps[2*TAP_W-1:TAP_W]] ^ m_g2[taps[TAP_W-1:0]];
      check_chip("ca_bit_o", chip, ca_bit_o);
      check_flag("result_valid_o", m_res_v, result_valid_o);
      check_flag("overflow_o", m_ovf, overflow_o);
      if (m_res_v) begin
         check_acc("result_i_o", m_res_i, result_i_o);
         check_acc("result_q_o", m_res_q, result_q_o);
      end
      if (result_valid_o) begin
         results_seen++;
         owed++;
      end
      if (owed > CREDIT_INIT) begin
         errors++;
         $display("%s: host received more results than credits granted", test_name);
      end
      case (disp_sel_i)
         2'd0:    dval = m_last_i;
         2'd1:    dval = m_last_q;
         2'd2:    dval = ACC_W'(m_chip_idx);
         default: dval = ACC_W'(m_dump_cnt);
      endcase
      check_hex("hex0_o", SEG_REF[dval[3:0]], hex0_o);
      check_hex("hex1_o", SEG_REF[dval[7:4]], hex1_o);
      check_hex("hex2_o", SEG_REF[dval[11:8]], hex2_o);
      check_hex("hex3_o", SEG_REF[dval[15:12]], hex3_o);
      en   = valid & (full_rate_i | m_tick);           // Tick from the previous edge
      csum = {1'b0, m_code_ph} + {1'b0, code_inc_i};   // Carry marks a new chip
      ep   = en && csum[NCO_W] && (m_chip_idx == CODE_LEN - 1);
      s    = int'($signed(sample_data_i));
      ti   = s * COS_REF[m_carr_ph[NCO_W-1 -: 3]] * (chip ? -1 : 1);
      tq   = -s * SIN_REF[m_carr_ph[NCO_W-1 -: 3]] * (chip ? -1 : 1);
      full = (fifo_i.size() == RES_FIFO_DEPTH);        // Both seen before this edge
      pop  = (fifo_i.size() != 0) && (m_credits != 0);
      m_res_v = pop;
      if (pop) begin
         m_res_i = fifo_i.pop_front();
         m_res_q = fifo_q.pop_front();
      end
      if (m_dump_v && full) m_ovf = 1'b1;              // Dump lost
      else if (m_dump_v) begin
         fifo_i.push_back(m_dump_i);
         fifo_q.push_back(m_dump_q);
      end
      m_credits = m_credits + int'(cret) - int'(pop);
      if (m_dump_v) begin
         m_last_i = m_dump_i;
         m_last_q = m_dump_q;
         m_dump_cnt++;
      end
      m_dump_v = ep;
      if (ep) begin                                    // Epoch sample is in the dump
         m_dump_i = ACC_W'(m_acc_i + ti);
         m_dump_q = ACC_W'(m_acc_q + tq);
         m_acc_i  = 0;
         m_acc_q  = 0;
      end else if (en) begin
         m_acc_i += ti;
         m_acc_q += tq;
      end
      if (en) begin
         m_code_ph = csum[NCO_W-1:0];
         m_carr_ph = m_carr_ph + carrier_inc_i;
      end
      if (ep) begin
         m_chip_idx = 0;
         m_g1       = '1;
         m_g2       = '1;
      end else if (en && csum[NCO_W]) begin
         m_chip_idx++;
         m_g1 = {m_g1[3] ^ m_g1[10], m_g1[1:9]};
         m_g2 = {m_g2[2] ^ m_g2[3] ^ m_g2[6] ^ m_g2[8] ^ m_g2[9] ^ m_g2[10], m_g2[1:9]};
      end
      m_tick = (m_div == 0);
      m_div  = (m_div == 0) ? PACE_DIV - 1 : m_div - 1;
      @(posedge clk_16_8);
      #1;
   endtask

   // Runs until the DUT has delivered n results, credits go back at once
   task automatic run_until(input int n, input logic rand_valid);
      while (results_seen < n)
         run_cycle(rand_valid ? (lfsr_take(2) != 0) : 1'b1, owed > 0);
   endtask

   initial begin
      rst_n_i         = 1'b0;
      sample_valid_i  = 1'b0;
      full_rate_i     = 1'b1;
      credit_return_i = 1'b0;
      sample_data_i   = '0;
      prn_i           = '0;
      code_inc_i      = 32'h8000_0000;                 // Two samples per chip
      carrier_inc_i   = '0;
      disp_sel_i      = '0;

      begin_test("reset");
      apply_reset();
      repeat (4) run_cycle(1'b0, 1'b0);
      check_flag("result_valid_o after reset", 1'b0, result_valid_o);
      check_flag("overflow_o after reset", 1'b0, overflow_o);
      check_hex("hex3_o after reset", SEG_REF[0], hex3_o);
      end_test();

      begin_test("code_sequence");
      repeat (3) begin
         prn_i = PRN_W'(lfsr_take(PRN_W));
         apply_reset();
         run_until(1, 1'b0);                           // One full period per PRN
      end
      end_test();

      begin_test("correlation");
      prn_i         = PRN_W'(lfsr_take(PRN_W));
      carrier_inc_i = lfsr_take(NCO_W);
      apply_reset();
      run_until(3, 1'b1);
      end_test();

      begin_test("credit_flow");
      apply_reset();
      while (m_dump_cnt < DUMPS_HELD) run_cycle(1'b1, 1'b0);
      check_acc("results without returns", ACC_W'(CREDIT_INIT), ACC_W'(results_seen));
      check_flag("overflow_o after held dumps", 1'b1, overflow_o);
      while (results_seen < CREDIT_INIT + RES_FIFO_DEPTH)
         run_cycle(1'b0, (owed > 0) && lfsr_take(1));
      repeat (40) run_cycle(1'b0, (owed > 0) && lfsr_take(1));
      check_acc("total results", ACC_W'(CREDIT_INIT + RES_FIFO_DEPTH), ACC_W'(results_seen));
      end_test();

      begin_test("divided_rate");
      full_rate_i   = 1'b0;
      carrier_inc_i = lfsr_take(NCO_W);
      apply_reset();
      run_until(1, 1'b0);
      full_rate_i   = 1'b1;
      end_test();

      begin_test("display");
      apply_reset();
      for (int sel = 0; sel < 4; sel++) begin
         disp_sel_i = DISP_SEL_W'(sel);
         run_until(sel + 1, 1'b0);
         repeat (8) run_cycle(1'b0, owed > 0);         // Chip index frozen
      end
      end_test();

      $display("%0d tests, %0d errors", tests, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("watchdog expired before the tests finished");
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== hdl/gps_channel_top.sv ====
module gps_channel_top import gps_pkg::*; (
   input  logic                    clk_16_8,         // 16.8 MHz sample clock
   input  logic                    rst_n_i,          // Sync reset, active low
   input  logic                    sample_valid_i,   // Feed strobe
   input  logic                    full_rate_i,      // 1 = 16.8 MHz, 0 = 200 kHz
   input  logic                    credit_return_i,  // Host returns one credit
   input  logic [SAMPLE_W-1:0]     sample_data_i,    // 3-bit IF sample
   input  logic [PRN_W-1:0]        prn_i,            // Satellite select
   input  logic [NCO_W-1:0]        code_inc_i,       // Code rate word
   input  logic [NCO_W-1:0]        carrier_inc_i,    // Carrier Doppler word
   input  logic [DISP_SEL_W-1:0]   disp_sel_i,       // Display source
   output logic                    ca_bit_o,         // Prompt C/A chip
   output logic                    result_valid_o,   // Result to host
   output logic                    overflow_o,       // Result lost, sticky
   output logic signed [ACC_W-1:0] result_i_o,
   output logic signed [ACC_W-1:0] result_q_o,
   output logic [SEG_W-1:0]        hex0_o,
   output logic [SEG_W-1:0]        hex1_o,
   output logic [SEG_W-1:0]        hex2_o,
   output logic [SEG_W-1:0]        hex3_o
);

   logic                        sample_en;   // Accepted sample
   logic signed [REPLICA_W-1:0] cos_rep;
   logic signed [REPLICA_W-1:0] sin_rep;
   logic                        chip;
   logic                        epoch;       // Code period boundary
   logic [CHIP_IDX_W-1:0]       chip_idx;
   logic                        dump_valid;
   logic signed [ACC_W-1:0]     dump_i;
   logic signed [ACC_W-1:0]     dump_q;

   assign ca_bit_o = chip;

   sample_pacer u_pacer (
      .clk_16_8(clk_16_8), .rst_n_i(rst_n_i), .sample_valid_i(sample_valid_i),
      .full_rate_i(full_rate_i), .sample_en_o(sample_en));

   carrier_nco u_carrier (
      .clk_16_8(clk_16_8), .rst_n_i(rst_n_i), .sample_en_i(sample_en),
      .carrier_inc_i(carrier_inc_i), .cos_o(cos_rep), .sin_o(sin_rep));

   ca_code_gen u_code (
      .clk_16_8(clk_16_8), .rst_n_i(rst_n_i), .sample_en_i(sample_en),
      .prn_i(prn_i), .code_inc_i(code_inc_i), .chip_o(chip),
      .epoch_o(epoch), .chip_idx_o(chip_idx));

   correlator u_corr (
      .clk_16_8(clk_16_8), .rst_n_i(rst_n_i), .sample_en_i(sample_en),
      .chip_i(chip), .epoch_i(epoch), .sample_i(sample_data_i),
      .cos_i(cos_rep), .sin_i(sin_rep), .dump_valid_o(dump_valid),
      .dump_i_o(dump_i), .dump_q_o(dump_q));

   result_credit_tx u_tx (
      .clk_16_8(clk_16_8), .rst_n_i(rst_n_i), .dump_valid_i(dump_valid),
      .credit_return_i(credit_return_i), .dump_i_i(dump_i), .dump_q_i(dump_q),
      .result_valid_o(result_valid_o), .overflow_o(overflow_o),
      .result_i_o(result_i_o), .result_q_o(result_q_o));

   status_display u_disp (
      .clk_16_8(clk_16_8), .rst_n_i(rst_n_i), .dump_valid_i(dump_valid),
      .dump_i_i(dump_i), .dump_q_i(dump_q), .chip_idx_i(chip_idx),
      .disp_sel_i(disp_sel_i), .hex0_o(hex0_o), .hex1_o(hex1_o),
      .hex2_o(hex2_o), .hex3_o(hex3_o));

endmodule

// ==== hdl/status_display.sv ====
module status_display import gps_pkg::*; (
   input  logic                    clk_16_8,      // Sample clock
   input  logic                    rst_n_i,       // Sync reset, active low
   input  logic                    dump_valid_i,  // Correlator dump strobe
   input  logic signed [ACC_W-1:0] dump_i_i,
   input  logic signed [ACC_W-1:0] dump_q_i,
   input  logic [CHIP_IDX_W-1:0]   chip_idx_i,    // Live code position
   input  logic [DISP_SEL_W-1:0]   disp_sel_i,    // Which value to show
   output logic [SEG_W-1:0]        hex0_o,        // Low nibble
   output logic [SEG_W-1:0]        hex1_o,
   output logic [SEG_W-1:0]        hex2_o,
   output logic [SEG_W-1:0]        hex3_o         // High nibble
);

   logic [ACC_W-1:0] last_i;     // Most recent dump
   logic [ACC_W-1:0] last_q;
   logic [ACC_W-1:0] dump_cnt;   // Dumps since reset, wraps
   logic [ACC_W-1:0] disp_val;   // Four hex digits

   // Hex digit to segments gfedcba, active low
   function automatic logic [SEG_W-1:0] seg_decode(input logic [NIB_W-1:0] nib);
      case (nib)
         4'h0: seg_decode = 7'h40;
         4'h1: seg_decode = 7'h79;
         4'h2: seg_decode = 7'h24;
         4'h3: seg_decode = 7'h30;
         4'h4: seg_decode = 7'h19;
         4'h5: seg_decode = 7'h12;
         4'h6: seg_decode = 7'h02;
         4'h7: seg_decode = 7'h78;
         4'h8: seg_decode = 7'h00;
         4'h9: seg_decode = 7'h10;
         4'hA: seg_decode = 7'h08;
         4'hB: seg_decode = 7'h03;
         4'hC: seg_decode = 7'h46;
         4'hD: seg_decode = 7'h21;
         4'hE: seg_decode = 7'h06;
         default: seg_decode = 7'h0E;  // F
      endcase
   endfunction

   // Capture every dump, zero after reset so digits read 0000
   always_ff @(posedge clk_16_8) begin
      if (!rst_n_i) begin
         last_i   <= '0;
         last_q   <= '0;
         dump_cnt <= '0;
      end else if (dump_valid_i) begin
         last_i   <= dump_i_i;
         last_q   <= dump_q_i;
         dump_cnt <= dump_cnt + 1'b1;
      end
   end

   always_comb begin
      case (disp_sel_i)
         2'd0:    disp_val = last_i;
         2'd1:    disp_val = last_q;
         2'd2:    disp_val = ACC_W'(chip_idx_i);  // Zero-extended
         default: disp_val = dump_cnt;
      endcase
   end

   assign hex0_o = seg_decode(disp_val[3:0]);
   assign hex1_o = seg_decode(disp_val[7:4]);
   assign hex2_o = seg_decode(disp_val[11:8]);
   assign hex3_o = seg_decode(disp_val[15:12]);

endmodule

// ==== hdl/result_credit_tx.sv ====
module result_credit_tx import gps_pkg::*; (
   input  logic                    clk_16_8,         // Sample clock
   input  logic                    rst_n_i,          // Sync reset, active low
   input  logic                    dump_valid_i,     // New I/Q pair from correlator
   input  logic                    credit_return_i,  // Host freed one slot
   input  logic signed [ACC_W-1:0] dump_i_i,
   input  logic signed [ACC_W-1:0] dump_q_i,
   output logic                    result_valid_o,   // One clock per result
   output logic                    overflow_o,       // Sticky, a dump was lost
   output logic signed [ACC_W-1:0] result_i_o,
   output logic signed [ACC_W-1:0] result_q_o
);

   logic signed [ACC_W-1:0] mem_i [RES_FIFO_DEPTH];  // Pair storage
   logic signed [ACC_W-1:0] mem_q [RES_FIFO_DEPTH];
   logic [RES_PTR_W-1:0]    wr_ptr;
   logic [RES_PTR_W-1:0]    rd_ptr;
   logic [RES_CNT_W-1:0]    fill;                    // Entries held
   logic [CREDIT_W-1:0]     credits;                 // Slots free at the host
   logic                    full;
   logic                    push;
   logic                    pop;

   assign full = (fill == RES_CNT_W'(RES_FIFO_DEPTH));
   assign push = dump_valid_i & ~full;                // Dump while full is dropped
   assign pop  = (fill != '0) & (credits != '0);      // One per clock with credit

   // Control state
   always_ff @(posedge clk_16_8) begin
      if (!rst_n_i) begin
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         fill           <= '0;
         credits        <= CREDIT_W'(CREDIT_INIT);
         result_valid_o <= 1'b0;
         overflow_o     <= 1'b0;
      end else begin
         result_valid_o <= pop;
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop) fill <= fill + 1'b1;
         else if (pop && !push) fill <= fill - 1'b1;
         if (pop && !credit_return_i) credits <= credits - 1'b1;  // Send consumes
         else if (credit_return_i && !pop) credits <= credits + 1'b1; // Both cancel
         if (dump_valid_i && full) overflow_o <= 1'b1;
      end
   end

   // Payload path
   always_ff @(posedge clk_16_8) begin
      if (push) begin
         mem_i[wr_ptr] <= dump_i_i;
         mem_q[wr_ptr] <= dump_q_i;
      end
      if (pop) begin
         result_i_o <= mem_i[rd_ptr];  // Held until next send
         result_q_o <= mem_q[rd_ptr];
      end
   end

endmodule

// ==== hdl/correlator.sv ====
module correlator import gps_pkg::*; (
   input  logic                        clk_16_8,      // Sample clock
   input  logic                        rst_n_i,       // Sync reset, active low
   input  logic                        sample_en_i,   // Accepted sample
   input  logic                        chip_i,        // Prompt chip, 1 maps to -1
   input  logic                        epoch_i,       // Sample closes the code period
   input  logic signed [SAMPLE_W-1:0]  sample_i,      // Raw sample
   input  logic signed [REPLICA_W-1:0] cos_i,         // Carrier replica I
   input  logic signed [REPLICA_W-1:0] sin_i,         // Carrier replica Q
   output logic                        dump_valid_o,  // One clock after epoch sample
   output logic signed [ACC_W-1:0]     dump_i_o,      // Prompt I over one period
   output logic signed [ACC_W-1:0]     dump_q_o       // Prompt Q over one period
);

   logic signed [ACC_W-1:0] prod_c;    // sample * cos
   logic signed [ACC_W-1:0] prod_s;    // sample * sin
   logic signed [ACC_W-1:0] term_i;    // After carrier and code wipe-off
   logic signed [ACC_W-1:0] term_q;
   logic signed [ACC_W-1:0] acc_i;     // Running prompt sums
   logic signed [ACC_W-1:0] acc_q;
   logic signed [ACC_W-1:0] sum_i;     // Sums including this sample
   logic signed [ACC_W-1:0] sum_q;

   // Mix down, products fit easily in ACC_W
   assign prod_c = ACC_W'(sample_i) * ACC_W'(cos_i);
   assign prod_s = ACC_W'(sample_i) * ACC_W'(sin_i);

   // Q uses -sin, code chip 1 flips both arms
   assign term_i = chip_i ? -prod_c : prod_c;
   assign term_q = chip_i ? prod_s : -prod_s;

   assign sum_i = acc_i + term_i;
   assign sum_q = acc_q + term_q;

   // Accumulators and dump strobe
   always_ff @(posedge clk_16_8) begin
      if (!rst_n_i) begin
         acc_i        <= '0;
         acc_q        <= '0;
         dump_valid_o <= 1'b0;
      end else begin
         dump_valid_o <= sample_en_i & epoch_i;
         if (sample_en_i) begin
            if (epoch_i) begin
               acc_i <= '0;            // Next period starts empty
               acc_q <= '0;
            end else begin
               acc_i <= sum_i;
               acc_q <= sum_q;
            end
         end
      end
   end

   // Dump data, epoch sample already included
   always_ff @(posedge clk_16_8) begin
      if (sample_en_i && epoch_i) begin
         dump_i_o <= sum_i;
         dump_q_o <= sum_q;
      end
   end

endmodule

// ==== hdl/ca_code_gen.sv ====
module ca_code_gen import gps_pkg::*; (
   input  logic                  clk_16_8,     // Sample clock
   input  logic                  rst_n_i,      // Sync reset, active low
   input  logic                  sample_en_i,  // Accepted sample
   input  logic [PRN_W-1:0]      prn_i,        // PRN number minus one
   input  logic [NCO_W-1:0]      code_inc_i,   // Code phase step, 2^32 = one chip
   output logic                  chip_o,       // Current C/A chip
   output logic                  epoch_o,      // Last chip of period ends on this sample
   output logic [CHIP_IDX_W-1:0] chip_idx_o    // Chip position 0..1022
);

   logic [NCO_W-1:0]      code_phase;   // Fractional chip phase
   logic [NCO_W:0]        code_sum;     // Carry out = chip boundary
   logic                  chip_adv;     // Move to next chip
   logic [CHIP_IDX_W-1:0] chip_idx;
   logic [CA_REG_W-1:0]   g1;           // Bit 0 = stage 1, bit 9 = stage 10
   logic [CA_REG_W-1:0]   g2;
   logic [2*TAP_W-1:0]    taps;         // G2 stage pair for this PRN
   logic [TAP_W-1:0]      tap_a;
   logic [TAP_W-1:0]      tap_b;
   logic                  g1_fb;        // 1 + x^3 + x^10
   logic                  g2_fb;        // 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10

   assign code_sum = {1'b0, code_phase} + {1'b0, code_inc_i};
   assign chip_adv = sample_en_i & code_sum[NCO_W];
   assign epoch_o  = chip_adv & (chip_idx == CHIP_IDX_W'(CODE_LEN - 1)); // 1022 -> 0

   assign g1_fb = g1[2] ^ g1[9];
   assign g2_fb = g2[1] ^ g2[2] ^ g2[5] ^ g2[7] ^ g2[8] ^ g2[9];

   // Phase selector taps, stages numbered from 1
   assign taps  = G2_TAPS[prn_i];
   assign tap_a = taps[2*TAP_W-1:TAP_W];
   assign tap_b = taps[TAP_W-1:0];

   // Outputs show state before the sample's update
   assign chip_o     = g1[CA_REG_W-1] ^ g2[tap_a - 4'd1] ^ g2[tap_b - 4'd1];
   assign chip_idx_o = chip_idx;

   always_ff @(posedge clk_16_8) begin
      if (!rst_n_i) begin
         code_phase <= '0;
         chip_idx   <= '0;
         g1         <= '1;                  // All ones at start of period
         g2         <= '1;
      end else if (sample_en_i) begin
         code_phase <= code_sum[NCO_W-1:0];
         if (epoch_o) begin
            chip_idx <= '0;                 // New period, reload both registers
            g1       <= '1;
            g2       <= '1;
         end else if (chip_adv) begin
            chip_idx <= chip_idx + 1'b1;
            g1       <= {g1[CA_REG_W-2:0], g1_fb};
            g2       <= {g2[CA_REG_W-2:0], g2_fb};
         end
      end
   end

endmodule

// ==== hdl/carrier_nco.sv ====
module carrier_nco import gps_pkg::*; (
   input  logic                        clk_16_8,       // Sample clock
   input  logic                        rst_n_i,        // Sync reset, active low
   input  logic                        sample_en_i,    // Advance phase on accepted sample
   input  logic [NCO_W-1:0]            carrier_inc_i,  // Phase step per sample
   output logic signed [REPLICA_W-1:0] cos_o,          // In-phase replica
   output logic signed [REPLICA_W-1:0] sin_o           // Quadrature replica
);

   logic [NCO_W-1:0]       phase;      // Carrier phase, full turn = 2^NCO_W
   logic [PHASE_IDX_W-1:0] phase_idx;  // Octant of the current phase

   // Phase accumulator, wraps naturally
   always_ff @(posedge clk_16_8) begin
      if (!rst_n_i) begin
         phase <= '0;
      end else if (sample_en_i) begin
         phase <= phase + carrier_inc_i;
      end
   end

   // Lookup uses phase before this sample's update
   assign phase_idx = phase[NCO_W-1 -: PHASE_IDX_W];

   assign cos_o = COS_TABLE[phase_idx];  // +-1 / +-3 levels
   assign sin_o = SIN_TABLE[phase_idx];

endmodule

// ==== hdl/sample_pacer.sv ====
module sample_pacer import gps_pkg::*; (
   input  logic clk_16_8,              // 16.8 MHz sample clock
   input  logic rst_n_i,               // Sync reset, active low
   input  logic sample_valid_i,        // Feed offers a sample
   input  logic full_rate_i,           // 1 = every clock, 0 = once per PACE_DIV
   output logic sample_en_o            // Sample accepted this clock
);

   logic [PACE_CNT_W-1:0] div_cnt;     // Down-counter, free running
   logic                  div_tick;    // High one clock in PACE_DIV

   // Divider runs from reset regardless of mode or valid
   always_ff @(posedge clk_16_8) begin
      if (!rst_n_i) begin
         div_cnt  <= PACE_CNT_W'(PACE_DIV - 1);
         div_tick <= 1'b0;
      end else begin
         div_tick <= (div_cnt == '0);  // Registered tick
         if (div_cnt == '0) begin
            div_cnt <= PACE_CNT_W'(PACE_DIV - 1); // Reload
         end else begin
            div_cnt <= div_cnt - 1'b1;
         end
      end
   end

   // Full rate passes valid straight on, divided mode waits for the tick
   assign sample_en_o = sample_valid_i & (full_rate_i | div_tick);

endmodule

// ==== hdl/gps_pkg.sv ====
package gps_pkg;

   // Sample and replica widths
   localparam int SAMPLE_W   = 3;              // Front-end sample, two's complement
   localparam int REPLICA_W  = 3;              // Carrier replica, values +-1 and +-3
   localparam int ACC_W      = 16;             // Accumulator and result width, signed

   // NCOs and code
   localparam int NCO_W      = 32;             // Phase accumulator for carrier and code
   localparam int CHIP_IDX_W = 10;             // Chip counter width
   localparam int CODE_LEN   = 1023;           // Chips per C/A period
   localparam int PRN_W      = 5;              // prn_i 0..31 selects PRN 1..32
   localparam int CA_REG_W   = 10;             // G1 and G2 register length
   localparam int TAP_W      = 4;              // One G2 stage number, 1..10

   // G2 phase select, {stage_a, stage_b} per PRN, stage 1 is the input end
   localparam logic [2*TAP_W-1:0] G2_TAPS [32] = '{
      8'h26, 8'h37, 8'h48, 8'h59,              // PRN 1-4
      8'h19, 8'h2A, 8'h18, 8'h29,              // PRN 5-8
      8'h3A, 8'h23, 8'h34, 8'h56,              // PRN 9-12
      8'h67, 8'h78, 8'h89, 8'h9A,              // PRN 13-16
      8'h14, 8'h25, 8'h36, 8'h47,              // PRN 17-20
      8'h58, 8'h69, 8'h13, 8'h46,              // PRN 21-24
      8'h57, 8'h68, 8'h79, 8'h8A,              // PRN 25-28
      8'h16, 8'h27, 8'h38, 8'h49               // PRN 29-32
   };

   // Eight-phase carrier replica, indexed by top 3 phase bits
   localparam logic signed [REPLICA_W-1:0] COS_TABLE [8] = '{
      3'sd3,  3'sd1,  -3'sd1, -3'sd3,          // 0 .. 135 deg
      -3'sd3, -3'sd1, 3'sd1,  3'sd3            // 180 .. 315 deg
   };
   localparam logic signed [REPLICA_W-1:0] SIN_TABLE [8] = '{
      3'sd1,  3'sd3,  3'sd3,  3'sd1,           // Upper half cycle
      -3'sd1, -3'sd3, -3'sd3, -3'sd1           // Lower half cycle
   };
   localparam int PHASE_IDX_W = 3;             // Bits of phase used for the lookup

   // Sample pacing
   localparam int PACE_DIV   = 84;             // 16.8 MHz / 84 = 200 kHz
   localparam int PACE_CNT_W = $clog2(PACE_DIV);

   // Result path toward the host
   localparam int RES_FIFO_DEPTH = 4;          // I/Q pairs held under back-pressure
   localparam int RES_PTR_W      = $clog2(RES_FIFO_DEPTH);
   localparam int RES_CNT_W      = $clog2(RES_FIFO_DEPTH + 1);
   localparam int CREDIT_INIT    = 2;          // Host buffer slots granted at reset
   localparam int CREDIT_W       = 3;

   // Status display
   localparam int DISP_SEL_W = 2;              // 0 I, 1 Q, 2 chip index, 3 dump count
   localparam int SEG_W      = 7;              // Segments per digit, active low
   localparam int NIB_W      = 4;              // Hex digit

endpackage
